// File: list.f
hdl/sifhPkg.sv
hdl/sifhControl.sv
hdl/binSelect.sv
hdl/histAccumulate.sv
hdl/histRam.sv
hdl/peakScan.sv
hdl/sifhTop.sv
dv/clockGen.sv
dv/sifhTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module sifhTb -o simSifh

./obj_dir/simSifh | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: dv/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    localparam int N = sifhPkg::NUM_SAMPLES;
    localparam int SAT_COUNT = 2 ** sifhPkg::CW - 1;
    localparam int READY_DELAY = 17;                    // clear of all bins plus one
    localparam int PASS_GAP = 3 + (sifhPkg::BINS + 2) + READY_DELAY - 1;
    localparam int LIMIT = 4 * 400;                     // four runs of about 400 cycles
    localparam int CLUSTER = 0;
    localparam int SAME = 1;
    localparam int TIE = 2;

    wire                      clk;
    wire                      res;
    logic                     start;
    sifhPkg::stampT           stamp;
    logic                     stampValid;
    wire                      stampReady;
    wire                      busy;
    wire                      resultValid;
    wire [2*sifhPkg::NB-1:0]  peakTime;
    wire [sifhPkg::CW-1:0]    peakCount;

    logic [31:0]              seed;
    sifhPkg::stampT           stamps [N];
    logic [sifhPkg::NB-1:0]   expCoarse;
    logic [2*sifhPkg::NB-1:0] expTime;
    logic [sifhPkg::CW-1:0]   expCount;
    int                       cycleCount;
    int                       sinceStart;   // cycles since the accepted start
    int                       lowCycles;    // length of the current stampReady low stretch
    int                       passAccepts;
    int                       results;
    logic                     inCoarse;

    clockGen clockGen_inst (.clk, .res);

    sifhTop sifhTop_inst (
        .clk, .res, .start, .stamp, .stampValid, .stampReady, .busy, .resultValid,
        .peakTime, .peakCount
    );

    assert property (@(posedge clk) disable iff (!res) !busy |-> !stampReady)
        else stopFail("stampReady high while the block is idle");
    assert property (@(posedge clk) disable iff (!res)
        $rose(stampReady) && inCoarse |-> sinceStart == READY_DELAY)
        else stopFail($sformatf("Fail stampReady delay 0x%h expected 0x%h",
                                $sampled(sinceStart), READY_DELAY));
    assert property (@(posedge clk) disable iff (!res)
        $rose(stampReady) && !inCoarse |-> lowCycles == PASS_GAP)
        else stopFail($sformatf("Fail stampReady gap 0x%h expected 0x%h",
                                $sampled(lowCycles), PASS_GAP));
    assert property (@(posedge clk) disable iff (!res) $fell(stampReady) |-> passAccepts == N)
        else stopFail($sformatf("Fail accepted samples 0x%h expected 0x%h",
                                $sampled(passAccepts), N));
    assert property (@(posedge clk) disable iff (!res) resultValid |=> !resultValid)
        else stopFail("resultValid held for more than one cycle");
    assert property (@(posedge clk) disable iff (!res) $rose(resultValid) |-> $fell(busy))
        else stopFail("busy did not fall together with resultValid");
    assert property (@(posedge clk) disable iff (!res) resultValid |-> peakTime == expTime)
        else stopFail($sformatf("Fail peakTime 0x%h expected 0x%h", peakTime, expTime));
    assert property (@(posedge clk) disable iff (!res) resultValid |-> peakCount == expCount)
        else stopFail($sformatf("Fail peakCount 0x%h expected 0x%h", peakCount, expCount));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cycleCount  <= 0;
            sinceStart  <= 0;
            lowCycles   <= 0;
            passAccepts <= 0;
            results     <= 0;
            inCoarse    <= 1'b0;
        end else begin
            cycleCount <= cycleCount + 1;
            sinceStart <= (start && !busy) ? 1 : sinceStart + 1;
            lowCycles  <= stampReady ? 0 : lowCycles + 1;
            if (stampValid && stampReady) passAccepts <= passAccepts + 1;
            else if (!stampReady) passAccepts <= 0;
            if (start && !busy) inCoarse <= 1'b1;
            else if (stampValid && stampReady) inCoarse <= 1'b0;   // first pass under way
            if (resultValid) results <= results + 1;
        end
    end

    always @(posedge clk) begin
        if (cycleCount == LIMIT) stopFail($sformatf("no result within %0d cycles", LIMIT));
    end

    task automatic stopFail(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {17'd0, seed[30:16]};               // upper bits, better spread
    endfunction

    function automatic sifhPkg::stampT makeStamp(input int kind, input bit fine, input int idx,
                                                 input logic [sifhPkg::NP-1:0] center);
        sifhPkg::stampT s;
        logic [31:0]    r;
        r = nextRand();
        s = r[sifhPkg::NP-1:0];
        if (kind == SAME) begin
            s = center;
        end else if (kind == TIE) begin
            s.coarse = fine ? 4'h3 : (idx[0] ? 4'h3 : 4'h9);   // coarse bins 3 and 9 level
            if (fine) s.fine = idx[0] ? 4'h5 : 4'hC;           // fine bins 5 and 12 level
        end else begin
            s = center + sifhPkg::NP'(r[8:0] % 9'd401) - 12'd200;   // spread of +-200
        end
        return s;
    endfunction

    // histogram of the held stamps with saturation, first maximum wins
    function automatic sifhPkg::peakT modelPeak(input bit fine, input logic [sifhPkg::NB-1:0] win);
        int                     cnt [sifhPkg::BINS];
        sifhPkg::peakT          best;
        logic [sifhPkg::NB-1:0] b;
        foreach (cnt[i]) cnt[i] = 0;
        best = '0;
        for (int i = 0; i < N; i++) begin
            b = fine ? stamps[i].fine : stamps[i].coarse;
            if ((!fine || stamps[i].coarse == win) && cnt[b] < SAT_COUNT) cnt[b] = cnt[b] + 1;
        end
        for (int i = 0; i < sifhPkg::BINS; i++) begin
            if (cnt[i] > int'(best.count)) begin
                best.bin   = sifhPkg::NB'(i);
                best.count = sifhPkg::CW'(cnt[i]);
            end
        end
        return best;
    endfunction

    // offers stamps until all of them are taken, ready or not
    task automatic drivePass(input int kind);
        int taken;
        int gap;
        taken = 0;
        gap = 0;
        while (taken < N) begin
            @(posedge clk);
            #10;
            stampValid = (gap == 0);
            stamp = stamps[taken];
            if (gap > 0) gap = gap - 1;
            @(negedge clk);
            if (stampValid && stampReady) begin     // accepted at the coming edge
                taken = taken + 1;
                if (kind != SAME && nextRand() % 4 == 0) gap = 1;
            end
        end
        @(posedge clk);
        #10;
        stampValid = 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        #10;
        start = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
    endtask

    task automatic runOnce(input int runIdx, input int kind,
                           input logic [sifhPkg::NP-1:0] center, input bit lateStart);
        sifhPkg::peakT p;
        for (int i = 0; i < N; i++) stamps[i] = makeStamp(kind, 1'b0, i, center);
        p = modelPeak(1'b0, '0);
        expCoarse = p.bin;
        pulseStart();
        drivePass(kind);
        for (int i = 0; i < N; i++) stamps[i] = makeStamp(kind, 1'b1, i, center);
        p = modelPeak(1'b1, expCoarse);
        expTime = {expCoarse, p.bin};
        expCount = p.count;
        if (lateStart) pulseStart();    // lands in the drain, must be ignored
        drivePass(kind);
        while (results == runIdx) @(negedge clk);
        repeat (2) @(negedge clk);
        assert (results == runIdx + 1)
            else stopFail($sformatf("Fail resultValid pulses 0x%h expected 0x%h",
                                    results, runIdx + 1));
        assert (!busy) else stopFail("busy still high after the result");
    endtask

    initial begin
        seed       = 32'd38284;
        start      = 1'b0;
        stampValid = 1'b0;
        stamp      = '0;
        @(posedge res);
        @(posedge clk);
        #10;
        assert (!stampReady && !busy && !resultValid)
            else stopFail("outputs active after reset before any start");
        runOnce(0, CLUSTER, sifhPkg::NP'(nextRand()), 1'b0);
        runOnce(1, SAME, 12'hA7C, 1'b0);     // one bin hit back to back, saturates
        runOnce(2, TIE, '0, 1'b0);
        runOnce(3, CLUSTER, sifhPkg::NP'(nextRand()), 1'b1);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic res
);

    localparam int HALF_PERIOD = 50;    // 100 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 res = 1'b1;                 // released like the other inputs
    end

endmodule

`default_nettype wire

// File: hdl/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire                      clk,
    input  wire                      res,
    input  wire                      start,
    input  wire sifhPkg::stampT      stamp,
    input  wire                      stampValid,
    output logic                     stampReady,
    output logic                     busy,
    output logic                     resultValid,
    output logic [2*sifhPkg::NB-1:0] peakTime,
    output logic [sifhPkg::CW-1:0]   peakCount
);

    logic                   stampAccept;
    sifhPkg::passT          pass;
    logic [sifhPkg::NB-1:0] window;
    sifhPkg::binReqT        req;
    logic [sifhPkg::NB-1:0] accRdAddr;
    logic                   accRdEn;
    logic [sifhPkg::CW-1:0] rdData;
    logic [sifhPkg::NB-1:0] wrAddr;
    logic                   wrEn;
    logic [sifhPkg::CW-1:0] wrData;
    logic                   accIdle;
    logic                   clearStart;
    logic                   clearBusy;
    logic                   scanStart;
    logic [sifhPkg::NB-1:0] scanRdAddr;
    logic                   scanBusy;
    logic                   scanDone;
    sifhPkg::peakT          scanPeak;

    assign stampAccept = stampValid & stampReady;

    sifhControl sifhControl_inst (
        .clk, .res, .start, .stampAccept, .accIdle, .clearBusy, .scanDone, .scanPeak,
        .stampReady, .busy, .pass, .window, .clearStart, .scanStart, .resultValid,
        .peakTime, .peakCount
    );

    binSelect binSelect_inst (
        .clk, .res, .stamp, .stampAccept, .pass, .window, .req
    );

    histAccumulate histAccumulate_inst (
        .clk, .res, .req, .rdAddr(accRdAddr), .rdEn(accRdEn), .rdData,
        .wrAddr, .wrEn, .wrData, .idle(accIdle)
    );

    histRam histRam_inst (
        .clk, .res, .clearStart, .accRdAddr, .accRdEn, .scanRdAddr, .scanBusy,
        .wrAddr, .wrEn, .wrData, .rdData, .clearBusy
    );

    peakScan peakScan_inst (
        .clk, .res, .scanStart, .rdData, .scanRdAddr, .scanBusy, .scanDone, .peak(scanPeak)
    );

endmodule

`default_nettype wire

// File: hdl/peakScan.sv
`timescale 1ns/1ps
`default_nettype none

module peakScan (
    input  wire                     clk,
    input  wire                     res,
    input  wire                     scanStart,
    input  wire [sifhPkg::CW-1:0]   rdData,
    output logic [sifhPkg::NB-1:0]  scanRdAddr,
    output logic                    scanBusy,
    output logic                    scanDone,
    output sifhPkg::peakT           peak
);

    logic                   cmpValid;  // rdData holds a bin this cycle
    logic [sifhPkg::NB-1:0] cmpBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanBusy   <= 1'b0;
            scanRdAddr <= '0;
            cmpValid   <= 1'b0;
            scanDone   <= 1'b0;
        end else begin
            cmpValid <= scanBusy;
            scanDone <= cmpValid && (cmpBin == sifhPkg::LAST_BIN);
            if (scanStart) begin
                scanBusy   <= 1'b1;
                scanRdAddr <= '0;
            end else if (scanBusy) begin
                scanRdAddr <= scanRdAddr + 1'b1;
                if (scanRdAddr == sifhPkg::LAST_BIN) scanBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= scanRdAddr;   // follows the registered read
        if (scanStart) begin
            peak <= '0;
        end else if (cmpValid && (rdData > peak.count)) begin
            peak.bin   <= cmpBin;   // strict compare keeps the lowest tie
            peak.count <= rdData;
        end
    end

endmodule

`default_nettype wire

// File: hdl/histRam.sv
`timescale 1ns/1ps
`default_nettype none

module histRam (
    input  wire                     clk,
    input  wire                     res,
    input  wire                     clearStart,
    input  wire [sifhPkg::NB-1:0]   accRdAddr,
    input  wire                     accRdEn,
    input  wire [sifhPkg::NB-1:0]   scanRdAddr,
    input  wire                     scanBusy,
    input  wire [sifhPkg::NB-1:0]   wrAddr,
    input  wire                     wrEn,
    input  wire [sifhPkg::CW-1:0]   wrData,
    output logic [sifhPkg::CW-1:0]  rdData,
    output logic                    clearBusy
);

    logic [sifhPkg::CW-1:0] mem [sifhPkg::BINS];
    logic [sifhPkg::NB-1:0] clearAddr;
    logic [sifhPkg::NB-1:0] portRdAddr;
    logic                   portRdEn;
    logic [sifhPkg::NB-1:0] portWrAddr;
    logic                   portWrEn;
    logic [sifhPkg::CW-1:0] portWrData;

    // scan owns the read port while it runs
    assign portRdAddr = scanBusy ? scanRdAddr : accRdAddr;
    assign portRdEn   = scanBusy || accRdEn;

    assign portWrEn   = clearBusy || wrEn;
    assign portWrAddr = clearBusy ? clearAddr : wrAddr;
    assign portWrData = clearBusy ? '0 : wrData;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearBusy <= 1'b0;
            clearAddr <= '0;
        end else if (clearStart) begin
            clearBusy <= 1'b1;
            clearAddr <= '0;
        end else if (clearBusy) begin
            clearAddr <= clearAddr + 1'b1;
            if (clearAddr == sifhPkg::LAST_BIN) clearBusy <= 1'b0;   // one zero per bin
        end
    end

    always_ff @(posedge clk) begin
        if (portWrEn) mem[portWrAddr] <= portWrData;
        if (portRdEn) rdData <= mem[portRdAddr];   // old word on same-address write
    end

endmodule

`default_nettype wire

// File: hdl/histAccumulate.sv
`timescale 1ns/1ps
`default_nettype none

module histAccumulate (
    input  wire                     clk,
    input  wire                     res,
    input  wire sifhPkg::binReqT    req,
    output logic [sifhPkg::NB-1:0]  rdAddr,
    output logic                    rdEn,
    input  wire [sifhPkg::CW-1:0]   rdData,
    output logic [sifhPkg::NB-1:0]  wrAddr,
    output logic                    wrEn,
    output logic [sifhPkg::CW-1:0]  wrData,
    output logic                    idle
);

    logic                   s2Valid;   // data stage
    logic [sifhPkg::NB-1:0] s2Bin;
    logic                   fwdValid;  // write issued last cycle
    logic [sifhPkg::NB-1:0] fwdBin;
    logic [sifhPkg::CW-1:0] fwdData;
    logic [sifhPkg::CW-1:0] base;

    // read issued in the request cycle
    assign rdAddr = req.bin;
    assign rdEn   = req.valid;

    // ram returned the old word if the same bin was written on the read edge
    assign base = (fwdValid && (fwdBin == s2Bin)) ? fwdData : rdData;

    assign wrEn   = s2Valid;
    assign wrAddr = s2Bin;
    assign wrData = (base == sifhPkg::SAT) ? base : base + 1'b1;

    assign idle = !req.valid && !s2Valid;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid  <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s2Valid  <= req.valid;
            fwdValid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s2Bin   <= req.bin;
        fwdBin  <= s2Bin;
        fwdData <= wrData;
    end

    // a bin hit again two cycles later reads its last write back from the ram
    assert property (@(posedge clk) disable iff (!res)
        (wrEn && $past(wrEn, 2) && (wrAddr == $past(wrAddr, 2))
            && !($past(wrEn) && (wrAddr == $past(wrAddr))))
        |-> (wrData == (($past(wrData, 2) == sifhPkg::SAT) ?
                        sifhPkg::SAT : $past(wrData, 2) + 1'b1)))
        else $error("bin count lost between a write and the next read");

endmodule

`default_nettype wire

// File: hdl/binSelect.sv
`timescale 1ns/1ps
`default_nettype none

module binSelect (
    input  wire                    clk,
    input  wire                    res,
    input  wire sifhPkg::stampT    stamp,
    input  wire                    stampAccept,
    input  wire sifhPkg::passT     pass,
    input  wire [sifhPkg::NB-1:0]  window,
    output sifhPkg::binReqT        req
);

    logic                  inWindow;
    logic                  validQ;
    logic [sifhPkg::NB-1:0] binQ;

    // coarse pass takes everything
    assign inWindow = (pass == sifhPkg::COARSE) || (stamp.coarse == window);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            validQ <= 1'b0;
        end else begin
            validQ <= stampAccept && inWindow;
        end
    end

    always_ff @(posedge clk) begin
        if (stampAccept) begin
            binQ <= (pass == sifhPkg::COARSE) ? stamp.coarse : stamp.fine;
        end
    end

    assign req.valid = validQ;
    assign req.bin   = binQ;

endmodule

`default_nettype wire

// File: hdl/sifhControl.sv
`timescale 1ns/1ps
`default_nettype none

module sifhControl (
    input  wire                      clk,
    input  wire                      res,
    input  wire                      start,
    input  wire                      stampAccept,
    input  wire                      accIdle,
    input  wire                      clearBusy,
    input  wire                      scanDone,
    input  wire sifhPkg::peakT       scanPeak,
    output logic                     stampReady,
    output logic                     busy,
    output sifhPkg::passT            pass,
    output logic [sifhPkg::NB-1:0]   window,
    output logic                     clearStart,
    output logic                     scanStart,
    output logic                     resultValid,
    output logic [2*sifhPkg::NB-1:0] peakTime,
    output logic [sifhPkg::CW-1:0]   peakCount
);

    typedef enum logic [2:0] {IDLE, CLEAR, BUILD, DRAIN, SCAN} stateT;

    stateT                   state;
    stateT                   stateNext;
    logic [sifhPkg::ACW-1:0] acceptCnt;
    logic                    scanFinish;

    assign scanFinish = (state == SCAN) && scanDone;
    // ready already in the cycle the clear finishes
    assign stampReady = (state == BUILD) || ((state == CLEAR) && !clearBusy);
    assign busy       = (state != IDLE);

    always_comb begin
        stateNext  = state;
        clearStart = 1'b0;
        scanStart  = 1'b0;
        case (state)
            IDLE: if (start) begin
                clearStart = 1'b1;
                stateNext  = CLEAR;
            end
            CLEAR: if (!clearBusy) stateNext = BUILD;
            BUILD: if (stampAccept && (acceptCnt == sifhPkg::LAST_SAMPLE)) stateNext = DRAIN;
            DRAIN: if (accIdle) begin          // last write has landed
                scanStart = 1'b1;
                stateNext = SCAN;
            end
            SCAN: if (scanDone) begin
                if (pass == sifhPkg::COARSE) begin
                    clearStart = 1'b1;          // second clear for the fine pass
                    stateNext  = CLEAR;
                end else begin
                    stateNext  = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= IDLE;
            pass        <= sifhPkg::COARSE;
            acceptCnt   <= '0;
            resultValid <= 1'b0;
        end else begin
            state       <= stateNext;
            resultValid <= scanFinish && (pass == sifhPkg::FINE);
            if (clearStart) acceptCnt <= '0;
            else if (stampAccept) acceptCnt <= acceptCnt + 1'b1;
            if (state == IDLE && start) pass <= sifhPkg::COARSE;
            else if (scanFinish) pass <= sifhPkg::FINE;
        end
    end

    always_ff @(posedge clk) begin
        if (scanFinish) begin
            if (pass == sifhPkg::COARSE) begin
                window <= scanPeak.bin;                 // coarse peak opens the fine window
            end else begin
                peakTime  <= {window, scanPeak.bin};
                peakCount <= scanPeak.count;
            end
        end
    end

    // a done only answers a scan that this FSM launched
    assert property (@(posedge clk) disable iff (!res) scanDone |-> (state == SCAN))
        else $error("scan done with no scan running");

    assert property (@(posedge clk) disable iff (!res) clearBusy |-> !stampReady)
        else $error("stampReady high during histogram clear");

endmodule

`default_nettype wire

// File: hdl/sifhPkg.sv
`default_nettype none

package sifhPkg;

    localparam int NP = 12;                  // timestamp width
    localparam int NB = 4;                   // bin index width
    localparam int BINS = 2 ** NB;
    localparam int CW = 6;                   // bin counter width
    localparam int NUM_SAMPLES = 96;         // accepted stamps per pass
    localparam int LW = NP - 2 * NB;         // bits below the fine field
    localparam int ACW = 7;                  // acceptance counter width

    localparam logic [NB-1:0] LAST_BIN = NB'(BINS - 1);
    localparam logic [CW-1:0] SAT = '1;      // counters stick here
    localparam logic [ACW-1:0] LAST_SAMPLE = ACW'(NUM_SAMPLES - 1);

    // which histogram is being built
    typedef enum logic [0:0] {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passT;

    // raw TDC word, msb first
    typedef struct packed {
        logic [NB-1:0] coarse;
        logic [NB-1:0] fine;
        logic [LW-1:0] low;
    } stampT;

    typedef struct packed {
        logic          valid;
        logic [NB-1:0] bin;
    } binReqT;

    typedef struct packed {
        logic [NB-1:0] bin;
        logic [CW-1:0] count;
    } peakT;

endpackage

`default_nettype wire
